/* vlog.f */
rtl/vram_pkg.sv
rtl/blit_pkg.sv
rtl/blit_regs.sv
rtl/blit_combine.sv
rtl/blit_seq.sv
rtl/blitter.sv
verif/tb_vram.sv
verif/blitter_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the blitter testbench with Verilator, run it and scan the log for a failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module blitter_tb -f vlog.f \
    -o blitter_sim > build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/blitter_sim > sim.log 2>&1
cat sim.log
grep -qF '** FAIL **' sim.log && { echo "simulation failed"; exit 1; }
grep -qF '** PASS **' sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

/* verif/blitter_tb.sv */
//////////////////////////////////////////////////
// Directed testbench for the blitter. Programs
// blits through the register port, runs them on a
// behavioural VRAM and compares a memory window
// with a word-by-word reference model
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module blitter_tb;

    localparam int WIN         = 1024;                  // checked VRAM window
    localparam int TOTAL_WORDS = 8 + 4*12 + 2*8 + 12 + 8;
    localparam int WATCHDOG_NS = TOTAL_WORDS*200 + 4000;

    typedef vram_pkg::word_t regs_t [10];               // index is the register number

    logic                   clk, reset_i, reg_wr_en_i, slow_ack;
    blit_pkg::reg_num_t     reg_num_i;
    vram_pkg::word_t        reg_data_i, vram_data_i, vram_data_o;
    vram_pkg::addr_t        vram_addr_o;
    vram_pkg::nibble_mask_t vram_wr_mask_o;
    logic                   vram_ack_i, busy_o, full_o, done_o, vram_sel_o, vram_wr_o;
    vram_pkg::word_t        exp_mem [0:WIN-1];
    int                     checks = 0;
    int                     errors = 0;
    int                     done_cnt = 0;

    blitter #(.LINE_COUNT_W(15)) blitter_i (.*);

    tb_vram vram_i (
        .clk, .reset_i, .slow_i(slow_ack), .sel_i(vram_sel_o), .wr_i(vram_wr_o),
        .mask_i(vram_wr_mask_o), .addr_i(vram_addr_o), .data_i(vram_data_o),
        .ack_o(vram_ack_i), .data_o(vram_data_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: blits did not finish within %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

    always @(negedge clk) begin
        if (done_o) done_cnt++;
    end

    task automatic check_word(input string what, input vram_pkg::word_t got,
                              input vram_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic set_word(input vram_pkg::addr_t a, input vram_pkg::word_t w);
        vram_i.poke(a, w);
        exp_mem[a] = w;
    endtask

    task automatic fill(input vram_pkg::word_t salt);
        for (int a = 0; a < WIN; a++) begin
            set_word(vram_pkg::addr_t'(a), vram_pkg::word_t'(a * 'h9e37) ^ salt);
        end
    endtask

    task automatic program_blit(input regs_t r);
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            reg_wr_en_i <= 1'b1;
            reg_num_i   <= blit_pkg::reg_num_t'(i);         // WORDS goes last and queues the blit
            reg_data_i  <= r[i];
        end
        @(posedge clk);
        reg_wr_en_i <= 1'b0;
    endtask

    task automatic wait_done();
        do begin
            @(negedge clk);
        end while (!done_o);
    endtask

    // reference: reads, logic op and transparent nibbles in DUT access order
    task automatic model_blit(input regs_t r);
        vram_pkg::addr_t a_ad, b_ad, d_ad;
        vram_pkg::word_t a, b, d, ctl;
        logic [7:0]      t;
        logic            hit;
        ctl  = r[0];
        t    = ctl[15:8];
        a_ad = r[2];
        b_ad = r[4];
        d_ad = r[7];
        a    = r[2];
        b    = r[4];
        for (int l = 0; l <= r[8]; l++) begin
            for (int w = 0; w <= r[9]; w++) begin
                if (!ctl[blit_pkg::CTRL_A_CONST]) begin
                    a = exp_mem[a_ad];
                    a_ad++;
                end
                if (!ctl[blit_pkg::CTRL_B_CONST]) begin
                    b = exp_mem[b_ad];
                    b_ad++;
                end
                d = (a & (ctl[blit_pkg::CTRL_B_NOT] ? ~b : b)) ^ r[5];
                for (int n = 0; n < 4; n++) begin
                    hit = ctl[blit_pkg::CTRL_TRANSP_8B] ? b[8*(n/2) +: 8] == t
                                                        : b[4*n +: 4] == t[4*(n%2) +: 4];
                    if (hit) d[4*n +: 4] = exp_mem[d_ad][4*n +: 4];
                end
                exp_mem[d_ad] = d;
                d_ad++;
            end
            a_ad += r[1];                               // line modulo
            b_ad += r[3];
            d_ad += r[6];
        end
    endtask

    task automatic check_window();
        for (int a = 0; a < WIN; a++) begin
            check_word($sformatf("VRAM word %0h", a), vram_i.peek(vram_pkg::addr_t'(a)),
                       exp_mem[a]);
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_bit("busy_o after reset", busy_o, 1'b0);
        check_bit("full_o after reset", full_o, 1'b0);
        check_bit("done_o after reset", done_o, 1'b0);
        check_bit("vram_sel_o after reset", vram_sel_o, 1'b0);
        check_bit("vram_wr_o after reset", vram_wr_o, 1'b0);
    endtask

    task automatic test_fill();
        regs_t r;
        int    base;
        fill(16'h1111);
        r = '{16'h0003, 16'h0000, 16'hf0f5, 16'h0000, 16'h3cc3, 16'h0ff0,
              16'h0000, 16'h0100, 16'h0000, 16'h0007};
        model_blit(r);
        program_blit(r);
        base = done_cnt;
        wait_done();
        check_bit("busy_o in done cycle", busy_o, 1'b0);
        repeat (3) @(negedge clk);
        check_bit("single done pulse", done_cnt == base + 1, 1'b1);
        check_window();
    endtask

    task automatic test_copy(input logic b_not, input logic slow);
        regs_t r;
        slow_ack <= slow;
        fill(16'h2222);                                 // same start image for every rerun
        r = '{{13'h0000, b_not, 2'b00}, 16'h0004, 16'h0010, 16'h0002, 16'h0040,
              16'h00ff, 16'h0008, 16'h0200, 16'h0002, 16'h0003};
        model_blit(r);
        program_blit(r);
        wait_done();
        check_window();
    endtask

    task automatic test_transp(input logic byte_mode);
        regs_t           r;
        vram_pkg::word_t tp [4];
        tp = '{16'h3a3a, 16'h3a71, 16'h713a, 16'h0a03};   // B words with some pixels equal to T
        fill(16'h3333);
        for (int i = 0; i < 8; i++) set_word(vram_pkg::addr_t'(16'h0340 + i), tp[i%4]);
        r = '{{8'h3a, 2'b00, byte_mode, 5'b00000}, 16'h0000, 16'h0300, 16'h0000,
              16'h0340, 16'h0000, 16'h0004, 16'h0380, 16'h0001, 16'h0003};
        model_blit(r);
        program_blit(r);
        wait_done();
        check_window();
    endtask

    task automatic test_queue();
        regs_t r1, r2;
        int    base;
        fill(16'h4444);
        r1 = '{16'h0000, 16'h0004, 16'h0010, 16'h0002, 16'h0040, 16'h00ff,
               16'h0008, 16'h0200, 16'h0002, 16'h0003};
        r2 = '{16'h5503, 16'h0000, 16'h1234, 16'h0000, 16'hfedc, 16'ha5a5,
               16'h0004, 16'h0300, 16'h0001, 16'h0003};
        model_blit(r1);
        model_blit(r2);
        program_blit(r1);
        base = done_cnt;
        do begin
            @(negedge clk);
        end while (!busy_o || full_o);                  // first blit taken by the sequencer
        program_blit(r2);
        @(negedge clk);
        check_bit("full_o with second blit queued", full_o, 1'b1);
        wait_done();
        check_bit("full_o at first done", full_o, 1'b1);
        check_bit("busy_o at first done", busy_o, 1'b1);
        wait_done();
        @(negedge clk);
        check_bit("full_o after second blit", full_o, 1'b0);
        check_bit("two done pulses", done_cnt == base + 2, 1'b1);
        check_window();
    endtask

    initial begin
        reset_i     = 1'b1;
        reg_wr_en_i = 1'b0;
        reg_num_i   = '0;
        reg_data_i  = '0;
        slow_ack    = 1'b0;
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        test_reset();
        test_fill();
        test_copy(1'b0, 1'b0);
        test_copy(1'b1, 1'b0);
        test_transp(1'b0);
        test_transp(1'b1);
        test_queue();
        test_copy(1'b0, 1'b1);                          // rerun with random ack delay
        test_copy(1'b1, 1'b1);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/tb_vram.sv */
//////////////////////////////////////////////////
// Behavioural VRAM for the blitter testbench.
// Acks each request after 0 to 3 random cycles when
// slow_i is set and writes only enabled nibbles
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module tb_vram (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   slow_i,       // random ack delay on
    input  wire logic                   sel_i,
    input  wire logic                   wr_i,
    input  wire vram_pkg::nibble_mask_t mask_i,
    input  wire vram_pkg::addr_t        addr_i,
    input  wire vram_pkg::word_t        data_i,
    output logic                        ack_o,
    output vram_pkg::word_t             data_o
);

    vram_pkg::word_t mem [0:65535];
    integer          seed = 32'ha801064f;
    int              wait_cnt;

    initial begin
        ack_o    = 1'b0;
        data_o   = '0;
        wait_cnt = 0;
    end

    always @(posedge clk) begin
        if (reset_i || ack_o) begin
            ack_o <= 1'b0;                              // ack lasts one cycle
        end else if (sel_i) begin
            if (wait_cnt == 0) begin
                ack_o  <= 1'b1;
                data_o <= mem[addr_i];
                if (wr_i) begin
                    for (int n = 0; n < 4; n++) begin
                        if (mask_i[n]) mem[addr_i][4*n +: 4] = data_i[4*n +: 4];
                    end
                end
                wait_cnt <= slow_i ? $unsigned($random(seed)) % 4 : 0;   // delay of next request
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    task automatic poke(input vram_pkg::addr_t a, input vram_pkg::word_t w);
        mem[a] = w;
    endtask

    function automatic vram_pkg::word_t peek(input vram_pkg::addr_t a);
        return mem[a];
    endfunction

endmodule

`default_nettype wire

/* rtl/blitter.sv */
//////////////////////////////////////////////////
// Blitter top level. Register bank, sequencer and
// combiner on a shared VRAM request/ack bus
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module blitter #(
    parameter int LINE_COUNT_W = 15
) (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    reg_wr_en_i,
    input  wire blit_pkg::reg_num_t      reg_num_i,
    input  wire vram_pkg::word_t         reg_data_i,
    input  wire logic                    vram_ack_i,
    input  wire vram_pkg::word_t         vram_data_i,
    output logic                         busy_o,
    output logic                         full_o,      // a blit is queued
    output logic                         done_o,
    output logic                         vram_sel_o,
    output logic                         vram_wr_o,
    output vram_pkg::nibble_mask_t       vram_wr_mask_o,
    output vram_pkg::addr_t              vram_addr_o,
    output vram_pkg::word_t              vram_data_o
);

    logic                   take;
    vram_pkg::word_t        ctrl, mod_a, src_a, mod_b, src_b, val_c, mod_d, dst_d, words;
    logic [LINE_COUNT_W-1:0] lines;
    vram_pkg::word_t        op_a, op_b, op_c;
    logic                   b_not, transp_8b;
    logic [7:0]             transp_t;

    blit_regs #(.LINE_COUNT_W(LINE_COUNT_W)) regs_i (
        .clk, .reset_i, .reg_wr_en_i, .reg_num_i, .reg_data_i,
        .take_i(take), .queued_o(full_o), .ctrl_o(ctrl),
        .mod_a_o(mod_a), .src_a_o(src_a), .mod_b_o(mod_b), .src_b_o(src_b),
        .val_c_o(val_c), .mod_d_o(mod_d), .dst_d_o(dst_d),
        .lines_o(lines), .words_o(words)
    );

    blit_seq #(.LINE_COUNT_W(LINE_COUNT_W)) seq_i (
        .clk, .reset_i, .queued_i(full_o), .ctrl_i(ctrl),
        .mod_a_i(mod_a), .src_a_i(src_a), .mod_b_i(mod_b), .src_b_i(src_b),
        .val_c_i(val_c), .mod_d_i(mod_d), .dst_d_i(dst_d),
        .lines_i(lines), .words_i(words), .vram_ack_i, .vram_data_i,
        .take_o(take), .busy_o, .done_o, .vram_sel_o, .vram_wr_o, .vram_addr_o,
        .val_a_o(op_a), .val_b_o(op_b), .val_c_o(op_c),
        .b_not_o(b_not), .transp_8b_o(transp_8b), .transp_t_o(transp_t)
    );

    blit_combine combine_i (
        .val_a_i(op_a), .val_b_i(op_b), .val_c_i(op_c), .b_not_i(b_not),
        .transp_8b_i(transp_8b), .transp_t_i(transp_t),
        .data_o(vram_data_o), .mask_o(vram_wr_mask_o)
    );

endmodule

`default_nettype wire

/* rtl/blit_seq.sv */
//////////////////////////////////////////////////
// Blit sequencer. Copies the queued blit into its
// working registers, then walks the rectangle: per
// word it reads A and B unless constant and writes
// D, holding each VRAM request until ack
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module blit_seq #(
    parameter int LINE_COUNT_W = 15
) (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    queued_i,
    input  wire vram_pkg::word_t         ctrl_i,
    input  wire vram_pkg::word_t         mod_a_i,
    input  wire vram_pkg::word_t         src_a_i,
    input  wire vram_pkg::word_t         mod_b_i,
    input  wire vram_pkg::word_t         src_b_i,
    input  wire vram_pkg::word_t         val_c_i,
    input  wire vram_pkg::word_t         mod_d_i,
    input  wire vram_pkg::word_t         dst_d_i,
    input  wire logic [LINE_COUNT_W-1:0] lines_i,
    input  wire vram_pkg::word_t         words_i,
    input  wire logic                    vram_ack_i,
    input  wire vram_pkg::word_t         vram_data_i,
    output logic                         take_o,
    output logic                         busy_o,
    output logic                         done_o,
    output logic                         vram_sel_o,
    output logic                         vram_wr_o,
    output vram_pkg::addr_t              vram_addr_o,
    output vram_pkg::word_t              val_a_o,
    output vram_pkg::word_t              val_b_o,
    output vram_pkg::word_t              val_c_o,
    output logic                         b_not_o,
    output logic                         transp_8b_o,
    output logic [7:0]                   transp_t_o
);

    blit_pkg::blit_state_t  state, next_state, word_start;
    logic                   a_const, b_const;
    vram_pkg::word_t        mod_a, mod_b, mod_d, words;
    vram_pkg::addr_t        src_a, src_b, dst_d;
    vram_pkg::addr_t        src_a_nx, src_b_nx, dst_d_nx;
    logic [LINE_COUNT_W:0]  line_cnt;                   // msb set on underflow
    logic [16:0]            word_cnt;
    logic                   last_line, last_word;

    assign last_line  = line_cnt[LINE_COUNT_W];
    assign last_word  = word_cnt[16];
    assign busy_o     = state != blit_pkg::IDLE;
    assign take_o     = state == blit_pkg::SETUP;
    assign vram_sel_o = state inside {blit_pkg::WAIT_RD_A, blit_pkg::WAIT_RD_B,
                                      blit_pkg::WAIT_WR_D};
    assign vram_wr_o  = state == blit_pkg::WAIT_WR_D;

    // first access of each word, skipping constant sources
    assign word_start = !a_const ? blit_pkg::WAIT_RD_A :
                        !b_const ? blit_pkg::WAIT_RD_B : blit_pkg::WAIT_WR_D;

    always_comb begin
        next_state = state;
        src_a_nx   = src_a;
        src_b_nx   = src_b;
        dst_d_nx   = dst_d;
        case (state)
            blit_pkg::IDLE: begin
                if (queued_i) begin
                    next_state = blit_pkg::SETUP;
                end
            end
            blit_pkg::SETUP: begin
                src_a_nx   = src_a_i;
                src_b_nx   = src_b_i;
                dst_d_nx   = dst_d_i;
                next_state = blit_pkg::LINE_BEG;
            end
            blit_pkg::LINE_BEG: next_state = word_start;
            blit_pkg::WAIT_RD_A: begin
                if (vram_ack_i) begin
                    src_a_nx   = src_a + 1'b1;
                    next_state = b_const ? blit_pkg::WAIT_WR_D : blit_pkg::WAIT_RD_B;
                end
            end
            blit_pkg::WAIT_RD_B: begin
                if (vram_ack_i) begin
                    src_b_nx   = src_b + 1'b1;
                    next_state = blit_pkg::WAIT_WR_D;
                end
            end
            blit_pkg::WAIT_WR_D: begin
                if (vram_ack_i) begin
                    dst_d_nx   = dst_d + 1'b1;
                    next_state = last_word ? blit_pkg::LINE_END : word_start;
                end
            end
            blit_pkg::LINE_END: begin
                src_a_nx = src_a + mod_a;               // line modulo
                src_b_nx = src_b + mod_b;
                dst_d_nx = dst_d + mod_d;
                if (!last_line) begin
                    next_state = blit_pkg::LINE_BEG;
                end else begin
                    next_state = queued_i ? blit_pkg::SETUP : blit_pkg::IDLE;
                end
            end
            default: next_state = blit_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state  <= blit_pkg::IDLE;
            done_o <= 1'b0;
        end else begin
            state  <= next_state;
            done_o <= (state == blit_pkg::LINE_END) && last_line;
        end
    end

    always_ff @(posedge clk) begin
        src_a <= src_a_nx;
        src_b <= src_b_nx;
        dst_d <= dst_d_nx;
        case (next_state)                               // address of the coming request
            blit_pkg::WAIT_RD_A: vram_addr_o <= src_a_nx;
            blit_pkg::WAIT_RD_B: vram_addr_o <= src_b_nx;
            default:             vram_addr_o <= dst_d_nx;
        endcase
        case (state)
            blit_pkg::SETUP: begin
                a_const     <= ctrl_i[blit_pkg::CTRL_A_CONST];
                b_const     <= ctrl_i[blit_pkg::CTRL_B_CONST];
                b_not_o     <= ctrl_i[blit_pkg::CTRL_B_NOT];
                transp_8b_o <= ctrl_i[blit_pkg::CTRL_TRANSP_8B];
                transp_t_o  <= ctrl_i[blit_pkg::CTRL_TRANSP_T_LSB +: 8];
                mod_a       <= mod_a_i;
                mod_b       <= mod_b_i;
                mod_d       <= mod_d_i;
                val_a_o     <= src_a_i;                 // constant if A is not read
                val_b_o     <= src_b_i;
                val_c_o     <= val_c_i;
                words       <= words_i;
                line_cnt    <= {1'b0, lines_i};
            end
            blit_pkg::LINE_BEG: begin
                line_cnt <= line_cnt - 1'b1;
                word_cnt <= {1'b0, words} - 17'd1;
            end
            blit_pkg::WAIT_RD_A: if (vram_ack_i) val_a_o <= vram_data_i;
            blit_pkg::WAIT_RD_B: if (vram_ack_i) val_b_o <= vram_data_i;
            blit_pkg::WAIT_WR_D: if (vram_ack_i) word_cnt <= word_cnt - 1'b1;
            default: begin
            end
        endcase
    end

    // a pending request keeps its address and direction until ack
    a_req_stable: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o && !vram_ack_i |=> vram_sel_o && $stable(vram_addr_o)
                                      && $stable(vram_wr_o));

    a_done_pulse: assert property (@(posedge clk) disable iff (reset_i)
        done_o |=> !done_o);

endmodule

`default_nettype wire

/* rtl/blit_combine.sv */
//////////////////////////////////////////////////
// Blitter data path: D = (A AND B') XOR C, plus the
// nibble write mask from the transparency test of
// B against T in 4-bit or 8-bit pixel mode
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module blit_combine (
    input  wire vram_pkg::word_t         val_a_i,
    input  wire vram_pkg::word_t         val_b_i,
    input  wire vram_pkg::word_t         val_c_i,
    input  wire logic                    b_not_i,
    input  wire logic                    transp_8b_i,
    input  wire logic [7:0]              transp_t_i,
    output vram_pkg::word_t              data_o,
    output vram_pkg::nibble_mask_t       mask_o
);

    vram_pkg::pixel_word_u  pix_b;
    vram_pkg::word_t        b_eff;
    vram_pkg::nibble_mask_t mask_4b;
    vram_pkg::nibble_mask_t mask_8b;

    assign pix_b  = val_b_i;                            // test uses B before inversion
    assign b_eff  = b_not_i ? ~val_b_i : val_b_i;
    assign data_o = (val_a_i & b_eff) ^ val_c_i;

    // even nibbles match T[3:0], odd nibbles T[7:4]
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            mask_4b[i] = pix_b.nibbles[i] != transp_t_i[4*(i%2) +: 4];
        end
    end

    assign mask_8b = {{2{pix_b.bytes[1] != transp_t_i}},
                      {2{pix_b.bytes[0] != transp_t_i}}};

    assign mask_o = transp_8b_i ? mask_8b : mask_4b;   // 0 keeps the old nibble

endmodule

`default_nettype wire

/* rtl/blit_regs.sv */
//////////////////////////////////////////////////
// Blitter register bank. Holds one queued blit
// written by strobe; a WORDS write marks it queued
// and the sequencer clears it with take_i
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module blit_regs #(
    parameter int LINE_COUNT_W = 15
) (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    reg_wr_en_i,
    input  wire blit_pkg::reg_num_t      reg_num_i,
    input  wire vram_pkg::word_t         reg_data_i,
    input  wire logic                    take_i,      // sequencer copied the queue
    output logic                         queued_o,
    output vram_pkg::word_t              ctrl_o,
    output vram_pkg::word_t              mod_a_o,
    output vram_pkg::word_t              src_a_o,
    output vram_pkg::word_t              mod_b_o,
    output vram_pkg::word_t              src_b_o,
    output vram_pkg::word_t              val_c_o,
    output vram_pkg::word_t              mod_d_o,
    output vram_pkg::word_t              dst_d_o,
    output logic [LINE_COUNT_W-1:0]      lines_o,
    output vram_pkg::word_t              words_o
);

    logic words_wr;

    assign words_wr = reg_wr_en_i && (reg_num_i == blit_pkg::REG_WORDS);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            queued_o <= 1'b0;
        end else if (words_wr) begin
            queued_o <= 1'b1;                           // new blit beats a take in the same cycle
        end else if (take_i) begin
            queued_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_wr_en_i) begin
            case (reg_num_i)
                blit_pkg::REG_CTRL:  ctrl_o  <= reg_data_i;
                blit_pkg::REG_MOD_A: mod_a_o <= reg_data_i;
                blit_pkg::REG_SRC_A: src_a_o <= reg_data_i;
                blit_pkg::REG_MOD_B: mod_b_o <= reg_data_i;
                blit_pkg::REG_SRC_B: src_b_o <= reg_data_i;
                blit_pkg::REG_VAL_C: val_c_o <= reg_data_i;
                blit_pkg::REG_MOD_D: mod_d_o <= reg_data_i;
                blit_pkg::REG_DST_D: dst_d_o <= reg_data_i;
                blit_pkg::REG_LINES: lines_o <= reg_data_i[LINE_COUNT_W-1:0];
                blit_pkg::REG_WORDS: words_o <= reg_data_i;
                default: begin
                end
            endcase
        end
    end

    // the sequencer only takes a blit that is actually waiting
    a_take_when_queued: assert property (@(posedge clk) disable iff (reset_i)
        take_i |-> queued_o);

endmodule

`default_nettype wire

/* rtl/blit_pkg.sv */
//////////////////////////////////////////////////
// Blitter register map, CTRL bit positions and the
// sequencer state encoding. Register numbers are
// what the host puts on reg_num_i
//////////////////////////////////////////////////

`default_nettype none

package blit_pkg;

    typedef logic [3:0] reg_num_t;

    localparam reg_num_t REG_CTRL  = 4'd0;
    localparam reg_num_t REG_MOD_A = 4'd1;      // added to A address at line end
    localparam reg_num_t REG_SRC_A = 4'd2;      // A address, or A constant
    localparam reg_num_t REG_MOD_B = 4'd3;
    localparam reg_num_t REG_SRC_B = 4'd4;      // B address, or B constant
    localparam reg_num_t REG_VAL_C = 4'd5;
    localparam reg_num_t REG_MOD_D = 4'd6;
    localparam reg_num_t REG_DST_D = 4'd7;
    localparam reg_num_t REG_LINES = 4'd8;      // line count minus 1
    localparam reg_num_t REG_WORDS = 4'd9;      // words per line minus 1, queues the blit

    localparam int CTRL_A_CONST      = 0;
    localparam int CTRL_B_CONST      = 1;
    localparam int CTRL_B_NOT        = 2;
    localparam int CTRL_TRANSP_8B    = 5;       // compare bytes instead of nibbles
    localparam int CTRL_TRANSP_T_LSB = 8;       // T occupies bits 15:8

    typedef enum logic [2:0] {
        IDLE, SETUP, LINE_BEG, WAIT_RD_A, WAIT_RD_B, WAIT_WR_D, LINE_END
    } blit_state_t;

endpackage

`default_nettype wire

/* rtl/vram_pkg.sv */
//////////////////////////////////////////////////
// VRAM bus types shared by the blitter and its
// testbench: word and address widths, nibble write
// enable and the two views of a pixel word
//////////////////////////////////////////////////

`default_nettype none

package vram_pkg;

    localparam int WORD_W = 16;                 // VRAM data width
    localparam int ADDR_W = 16;                 // VRAM word address width

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [3:0]        nibble_mask_t;   // one enable per nibble, bit 0 is the low nibble

    // the same 16 bits read as 4-bit or as 8-bit pixels
    typedef union packed {
        logic [3:0][3:0] nibbles;
        logic [1:0][7:0] bytes;
    } pixel_word_u;

endpackage

`default_nettype wire
